/* logic/rib_pkg.sv */
`default_nettype none

package rib_pkg;

    localparam int MemAddrBus = 32;  // address width
    localparam int MemBus     = 32;  // data width

    typedef logic [MemAddrBus-1:0] addr_t;
    typedef logic [MemBus-1:0]     data_t;
    typedef logic [3:0]            region_t;  // addr[31:28]

    // slave regions, top four address bits
    localparam region_t RegionRam   = 4'd0;
    localparam region_t RegionGpio  = 4'd1;
    localparam region_t RegionTimer = 4'd2;

    localparam data_t INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

    localparam int RamDepth = 256;  // words
    typedef logic [7:0] RamIdx_t;   // addr[9:2]

    localparam int GpioWidth = 8;
    typedef logic [GpioWidth-1:0] gpio_t;

    // register offsets from addr[3:2]
    localparam logic [1:0] GpioOutOff = 2'd0;
    localparam logic [1:0] GpioInOff  = 2'd1;

    localparam logic [1:0] TmrCtrlOff  = 2'd0;  // bit0 enable, bit1 pending
    localparam logic [1:0] TmrCountOff = 2'd1;
    localparam logic [1:0] TmrCmpOff   = 2'd2;

endpackage

`default_nettype wire

/* logic/rib_slave_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface rib_slave_if;
    import rib_pkg::*;

    addr_t addr;   // full bus address
    data_t wdata;  // write data from winner
    logic  we;     // only high on the decoded slave
    data_t rdata;  // combinational read data

    modport bus (
        output addr, wdata, we,
        input  rdata
    );

    modport slave (
        input  addr, wdata, we,
        output rdata
    );

endinterface

`default_nettype wire

/* logic/ram_blk.sv */
`timescale 1ns/1ns
`default_nettype none

module ram_blk (
    input  logic      clk,
    input  logic      arst_n_i,
    rib_slave_if.slave bus_i
);
    import rib_pkg::*;

    data_t   mem [RamDepth];  // word array, no reset
    RamIdx_t idx;             // word index

    assign idx = bus_i.addr[9:2];

    // combinational read in the request cycle
    assign bus_i.rdata = mem[idx];

    // no writes land while reset is asserted
    always_ff @(posedge clk) begin
        if (arst_n_i && bus_i.we) begin
            mem[idx] <= bus_i.wdata;
        end
    end

endmodule

`default_nettype wire

/* logic/gpio_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module gpio_regs (
    input  logic           clk,
    input  logic           arst_n_i,
    rib_slave_if.slave     bus_i,
    input  rib_pkg::gpio_t gpio_i,   // raw pins, not synchronized
    output rib_pkg::gpio_t gpio_o
);
    import rib_pkg::*;

    gpio_t      out_q;   // output register
    logic [1:0] offset;  // register select

    assign offset = bus_i.addr[3:2];
    assign gpio_o = out_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
        end else if (bus_i.we && offset == GpioOutOff) begin
            out_q <= bus_i.wdata[GpioWidth-1:0];
        end
    end

    // readback, zero extended to bus width
    always_comb begin
        case (offset)
            GpioOutOff: bus_i.rdata = {{(MemBus-GpioWidth){1'b0}}, out_q};
            GpioInOff:  bus_i.rdata = {{(MemBus-GpioWidth){1'b0}}, gpio_i};
            default:    bus_i.rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/timer_blk.sv */
`timescale 1ns/1ns
`default_nettype none

module timer_blk (
    input  logic       clk,
    input  logic       arst_n_i,
    rib_slave_if.slave bus_i,
    output logic       int_o    // pending flag
);
    import rib_pkg::*;

    logic       enable_q;
    logic       pending_q;
    data_t      count_q;
    data_t      cmp_q;
    logic [1:0] offset;
    logic       hit;       // count reached compare

    assign offset = bus_i.addr[3:2];
    assign hit    = enable_q && (count_q == cmp_q);
    assign int_o  = pending_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
            count_q   <= '0;
            cmp_q     <= '0;
        end else begin
            if (hit) begin
                count_q <= '0;     // wrap on match
            end else if (enable_q) begin
                count_q <= count_q + data_t'(1);
            end
            if (bus_i.we) begin
                case (offset)
                    TmrCtrlOff:  enable_q <= bus_i.wdata[0];
                    TmrCountOff: count_q  <= bus_i.wdata;  // bus write wins
                    TmrCmpOff:   cmp_q    <= bus_i.wdata;
                    default: ;
                endcase
            end
            // set beats clear so a match is never lost
            if (hit) begin
                pending_q <= 1'b1;
            end else if (bus_i.we && offset == TmrCtrlOff && bus_i.wdata[1]) begin
                pending_q <= 1'b0;  // write one to clear
            end
        end
    end

    always_comb begin
        case (offset)
            TmrCtrlOff:  bus_i.rdata = {{(MemBus-2){1'b0}}, pending_q, enable_q};
            TmrCountOff: bus_i.rdata = count_q;
            TmrCmpOff:   bus_i.rdata = cmp_q;
            default:     bus_i.rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/rib.sv */
`timescale 1ns/1ns
`default_nettype none

module rib (
    input  rib_pkg::addr_t m0_addr_i,
    input  rib_pkg::data_t m0_data_i,
    input  logic           m0_req_i,
    input  logic           m0_we_i,
    output rib_pkg::data_t m0_data_o,

    input  rib_pkg::addr_t m1_addr_i,   // instruction fetch
    input  rib_pkg::data_t m1_data_i,
    input  logic           m1_req_i,
    input  logic           m1_we_i,
    output rib_pkg::data_t m1_data_o,

    input  rib_pkg::addr_t m2_addr_i,
    input  rib_pkg::data_t m2_data_i,
    input  logic           m2_req_i,
    input  logic           m2_we_i,
    output rib_pkg::data_t m2_data_o,

    input  rib_pkg::addr_t m3_addr_i,
    input  rib_pkg::data_t m3_data_i,
    input  logic           m3_req_i,
    input  logic           m3_we_i,
    output rib_pkg::data_t m3_data_o,

    rib_slave_if.bus       ram_o,
    rib_slave_if.bus       gpio_o,
    rib_slave_if.bus       timer_o,

    output logic           hold_flag_o  // stall request to the core
);
    import rib_pkg::*;

    logic [3:0] req;        // ordered m3, m0, m2, m1
    addr_t      bus_addr;   // winner's address
    data_t      bus_wdata;
    logic       bus_we;
    data_t      bus_rdata;  // from decoded slave
    region_t    region;

    assign req    = {m3_req_i, m0_req_i, m2_req_i, m1_req_i};
    assign region = bus_addr[MemAddrBus-1:MemAddrBus-4];

    // fixed priority arbiter, m1 wins by default
    always_comb begin
        m0_data_o = '0;
        m1_data_o = INST_NOP;  // core sees a bubble while stalled
        m2_data_o = '0;
        m3_data_o = '0;
        casez (req)
            4'b1???: begin
                hold_flag_o = 1'b1;
                bus_addr    = m3_addr_i;
                bus_wdata   = m3_data_i;
                bus_we      = m3_we_i;
                m3_data_o   = bus_rdata;
            end
            4'b01??: begin
                hold_flag_o = 1'b1;
                bus_addr    = m0_addr_i;
                bus_wdata   = m0_data_i;
                bus_we      = m0_we_i;
                m0_data_o   = bus_rdata;
            end
            4'b001?: begin
                hold_flag_o = 1'b1;
                bus_addr    = m2_addr_i;
                bus_wdata   = m2_data_i;
                bus_we      = m2_we_i;
                m2_data_o   = bus_rdata;
            end
            default: begin
                hold_flag_o = 1'b0;
                bus_addr    = m1_addr_i;
                bus_wdata   = m1_data_i;
                bus_we      = m1_we_i;   // honored even without m1_req_i
                m1_data_o   = bus_rdata;
            end
        endcase
    end

    // region decode, only the selected slave sees the access
    always_comb begin
        ram_o.addr    = '0;
        ram_o.wdata   = '0;
        ram_o.we      = 1'b0;
        gpio_o.addr   = '0;
        gpio_o.wdata  = '0;
        gpio_o.we     = 1'b0;
        timer_o.addr  = '0;
        timer_o.wdata = '0;
        timer_o.we    = 1'b0;
        bus_rdata     = '0;  // unmapped reads as zero
        case (region)
            RegionRam: begin
                ram_o.addr  = bus_addr;
                ram_o.wdata = bus_wdata;
                ram_o.we    = bus_we;
                bus_rdata   = ram_o.rdata;
            end
            RegionGpio: begin
                gpio_o.addr  = bus_addr;
                gpio_o.wdata = bus_wdata;
                gpio_o.we    = bus_we;
                bus_rdata    = gpio_o.rdata;
            end
            RegionTimer: begin
                timer_o.addr  = bus_addr;
                timer_o.wdata = bus_wdata;
                timer_o.we    = bus_we;
                bus_rdata     = timer_o.rdata;
            end
            default: ;  // writes dropped
        endcase
    end

endmodule

`default_nettype wire

/* logic/rib_soc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rib_soc_top (
    input  logic           clk,
    input  logic           arst_n_i,

    input  rib_pkg::addr_t m0_addr_i,
    input  rib_pkg::data_t m0_data_i,
    input  logic           m0_req_i,
    input  logic           m0_we_i,
    output rib_pkg::data_t m0_data_o,

    input  rib_pkg::addr_t m1_addr_i,
    input  rib_pkg::data_t m1_data_i,
    input  logic           m1_req_i,
    input  logic           m1_we_i,
    output rib_pkg::data_t m1_data_o,

    input  rib_pkg::addr_t m2_addr_i,
    input  rib_pkg::data_t m2_data_i,
    input  logic           m2_req_i,
    input  logic           m2_we_i,
    output rib_pkg::data_t m2_data_o,

    input  rib_pkg::addr_t m3_addr_i,
    input  rib_pkg::data_t m3_data_i,
    input  logic           m3_req_i,
    input  logic           m3_we_i,
    output rib_pkg::data_t m3_data_o,

    output logic           hold_flag_o,
    input  rib_pkg::gpio_t gpio_i,
    output rib_pkg::gpio_t gpio_o,
    output logic           int_o
);

    rib_slave_if ram_if ();    // region 0
    rib_slave_if gpio_if ();   // region 1
    rib_slave_if timer_if ();  // region 2

    rib u_rib (
        .m0_addr_i  (m0_addr_i),
        .m0_data_i  (m0_data_i),
        .m0_req_i   (m0_req_i),
        .m0_we_i    (m0_we_i),
        .m0_data_o  (m0_data_o),
        .m1_addr_i  (m1_addr_i),
        .m1_data_i  (m1_data_i),
        .m1_req_i   (m1_req_i),
        .m1_we_i    (m1_we_i),
        .m1_data_o  (m1_data_o),
        .m2_addr_i  (m2_addr_i),
        .m2_data_i  (m2_data_i),
        .m2_req_i   (m2_req_i),
        .m2_we_i    (m2_we_i),
        .m2_data_o  (m2_data_o),
        .m3_addr_i  (m3_addr_i),
        .m3_data_i  (m3_data_i),
        .m3_req_i   (m3_req_i),
        .m3_we_i    (m3_we_i),
        .m3_data_o  (m3_data_o),
        .ram_o      (ram_if.bus),
        .gpio_o     (gpio_if.bus),
        .timer_o    (timer_if.bus),
        .hold_flag_o(hold_flag_o)
    );

    ram_blk u_ram (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .bus_i   (ram_if.slave)
    );

    gpio_regs u_gpio (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .bus_i   (gpio_if.slave),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o)
    );

    timer_blk u_timer (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .bus_i   (timer_if.slave),
        .int_o   (int_o)
    );

endmodule

`default_nettype wire

/* sim/rib_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rib_tb;
    import rib_pkg::*;

    localparam int    ClkPeriod   = 40;
    localparam int    ResetCycles = 5;
    localparam int    MaxTxn      = 32;            // table capacity
    localparam int    TimerBound  = 20;            // cycles allowed for int_o to rise
    localparam int    TimerBudget = 60;            // cycles spent in the timer test
    localparam addr_t IdleAddr    = 32'h5000_0000; // unmapped, reads zero
    localparam data_t TimerCmp    = 32'd10;

    logic  clk;
    logic  arst_n;
    addr_t m_addr [4];
    data_t m_wdata [4];
    logic  m_req [4];
    logic  m_we [4];
    data_t m_rdata [4];
    logic  hold_flag;
    gpio_t gpio_in;
    gpio_t gpio_out;
    logic  int_flag;

    // table columns, one row per transaction, master n in bit or slot n
    string      t_name [MaxTxn];
    logic [3:0] t_req [MaxTxn];
    logic [3:0] t_we [MaxTxn];
    addr_t      t_addr [MaxTxn][4];
    data_t      t_wdata [MaxTxn][4];
    gpio_t      t_pins [MaxTxn];
    data_t      t_exp [MaxTxn][4];
    logic [3:0] t_chk [MaxTxn];      // cleared where the RAM word is still unknown
    logic       t_hold [MaxTxn];
    gpio_t      t_gpio [MaxTxn];
    int         n_txn = 0;

    data_t ram_model [RamDepth];
    logic  ram_known [RamDepth];
    gpio_t gpio_model;
    gpio_t cur_pins;

    int seed       = 75;
    int err_count  = 0;
    int pass_count = 0;
    int fail_count = 0;

    rib_soc_top dut_i (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .m0_addr_i  (m_addr[0]),
        .m0_data_i  (m_wdata[0]),
        .m0_req_i   (m_req[0]),
        .m0_we_i    (m_we[0]),
        .m0_data_o  (m_rdata[0]),
        .m1_addr_i  (m_addr[1]),
        .m1_data_i  (m_wdata[1]),
        .m1_req_i   (m_req[1]),
        .m1_we_i    (m_we[1]),
        .m1_data_o  (m_rdata[1]),
        .m2_addr_i  (m_addr[2]),
        .m2_data_i  (m_wdata[2]),
        .m2_req_i   (m_req[2]),
        .m2_we_i    (m_we[2]),
        .m2_data_o  (m_rdata[2]),
        .m3_addr_i  (m_addr[3]),
        .m3_data_i  (m_wdata[3]),
        .m3_req_i   (m_req[3]),
        .m3_we_i    (m_we[3]),
        .m3_data_o  (m_rdata[3]),
        .hold_flag_o(hold_flag),
        .gpio_i     (gpio_in),
        .gpio_o     (gpio_out),
        .int_o      (int_flag)
    );

    always #(ClkPeriod/2) clk = ~clk;

    function automatic data_t model_read(addr_t a, gpio_t pins);
        if (a[31:28] == RegionRam) begin
            return ram_model[a[9:2]];
        end else if (a[31:28] == RegionGpio && a[3:2] == GpioOutOff) begin
            return data_t'(gpio_model);
        end else if (a[31:28] == RegionGpio && a[3:2] == GpioInOff) begin
            return data_t'(pins);
        end
        return '0;  // unmapped region
    endfunction

    // one table row, expected values follow the priority order m3, m0, m2, m1
    task automatic add_txn(string name, logic [3:0] mask, addr_t a, data_t d,
                           logic [3:0] wmask);
        int    w;
        addr_t wa;
        w = mask[3] ? 3 : (mask[0] ? 0 : (mask[2] ? 2 : 1));
        t_name[n_txn] = name;
        t_req[n_txn]  = mask;
        t_we[n_txn]   = mask & wmask;
        t_pins[n_txn] = cur_pins;
        t_chk[n_txn]  = 4'b1111;
        for (int m = 0; m < 4; m++) begin
            t_addr[n_txn][m]  = mask[m] ? a : IdleAddr;
            t_wdata[n_txn][m] = mask[m] ? d + m : '0;     // each master its own word
            t_exp[n_txn][m]   = (m == 1) ? INST_NOP : '0;
        end
        wa = t_addr[n_txn][w];
        t_exp[n_txn][w] = model_read(wa, cur_pins);
        t_chk[n_txn][w] = (wa[31:28] != RegionRam) || ram_known[wa[9:2]];
        t_hold[n_txn]   = (w != 1);
        t_gpio[n_txn]   = gpio_model;  // register value before this edge
        if (t_we[n_txn][w] && wa[31:28] == RegionRam) begin
            ram_model[wa[9:2]] = t_wdata[n_txn][w];
            ram_known[wa[9:2]] = 1'b1;
        end else if (t_we[n_txn][w] && wa[31:28] == RegionGpio && wa[3:2] == GpioOutOff) begin
            gpio_model = t_wdata[n_txn][w][GpioWidth-1:0];
        end
        n_txn++;
    endtask

    task automatic build_table();
        cur_pins = 8'h3c;
        add_txn("reset idle", 4'b0000, IdleAddr, '0, 4'b0000);
        add_txn("m0 wr ram 0x010", 4'b0001, 32'h0000_0010, $random(seed), 4'b0001);
        add_txn("m2 rd ram 0x010", 4'b0100, 32'h0000_0010, '0, 4'b0000);
        add_txn("m2 wr ram 0x024", 4'b0100, 32'h0000_0024, $random(seed), 4'b0100);
        add_txn("m3 rd ram 0x024", 4'b1000, 32'h0000_0024, '0, 4'b0000);
        add_txn("m3 wr ram 0x3fc", 4'b1000, 32'h0000_03fc, $random(seed), 4'b1000);
        add_txn("m1 rd ram 0x3fc", 4'b0010, 32'h0000_03fc, '0, 4'b0000);
        add_txn("m0 wr ram 0x000", 4'b0001, 32'h0000_0000, $random(seed), 4'b0001);
        add_txn("m1 rd ram 0x000", 4'b0010, 32'h0000_0000, '0, 4'b0000);
        add_txn("prio all wr 0x040", 4'b1111, 32'h0000_0040, $random(seed), 4'b1111);
        add_txn("prio m1 rd 0x040", 4'b0010, 32'h0000_0040, '0, 4'b0000);
        add_txn("prio m0 m2 m1 wr 0x044", 4'b0111, 32'h0000_0044, $random(seed), 4'b0111);
        add_txn("prio m2 rd 0x044", 4'b0100, 32'h0000_0044, '0, 4'b0000);
        add_txn("prio m2 m1 wr 0x048", 4'b0110, 32'h0000_0048, $random(seed), 4'b0110);
        add_txn("prio m3 rd 0x048", 4'b1000, 32'h0000_0048, '0, 4'b0000);
        add_txn("gpio wr out", 4'b0001, 32'h1000_0000, 32'h0000_00a5, 4'b0001);
        add_txn("gpio rd out", 4'b0100, 32'h1000_0000, '0, 4'b0000);
        add_txn("gpio rd pins", 4'b1000, 32'h1000_0004, '0, 4'b0000);
        add_txn("gpio wr pins ignored", 4'b0001, 32'h1000_0004, 32'h0000_00ff, 4'b0001);
        cur_pins = 8'hc3;
        add_txn("gpio rd out again", 4'b0010, 32'h1000_0000, '0, 4'b0000);
        add_txn("gpio rd new pins", 4'b0100, 32'h1000_0004, '0, 4'b0000);
        add_txn("unmapped wr", 4'b0001, 32'h5000_0010, $random(seed), 4'b0001);
        add_txn("unmapped rd", 4'b0100, 32'h5000_0010, '0, 4'b0000);
        add_txn("ram after unmapped", 4'b1000, 32'h0000_0010, '0, 4'b0000);
    endtask

    task automatic idle_masters();
        for (int m = 0; m < 4; m++) begin
            m_addr[m]  = IdleAddr;  // m1 keeps the grant but reads zero
            m_wdata[m] = '0;
            m_req[m]   = 1'b0;
            m_we[m]    = 1'b0;
        end
    endtask

    task automatic apply_txn(int i);
        for (int m = 0; m < 4; m++) begin
            m_addr[m]  = t_addr[i][m];
            m_wdata[m] = t_wdata[i][m];
            m_req[m]   = t_req[i][m];
            m_we[m]    = t_we[i][m];
        end
        gpio_in = t_pins[i];
    endtask

    task automatic check_value(string what, data_t exp, data_t act);
        if (act !== exp) begin
            err_count++;
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", what, exp, act);
        end
    endtask

    task automatic report_test(string name, int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %s ok", name);
        end else begin
            fail_count++;
            $display("test %s failed", name);
        end
    endtask

    task automatic check_txn(int i);
        int errs_before;
        errs_before = err_count;
        for (int m = 0; m < 4; m++) begin
            if (t_chk[i][m]) begin
                check_value($sformatf("%s m%0d_data_o", t_name[i], m),
                            t_exp[i][m], m_rdata[m]);
            end
        end
        check_value({t_name[i], " hold_flag_o"}, {31'b0, t_hold[i]}, {31'b0, hold_flag});
        check_value({t_name[i], " gpio_o"}, data_t'(t_gpio[i]), data_t'(gpio_out));
        check_value({t_name[i], " int_o"}, '0, {31'b0, int_flag});  // timer stays off
        report_test(t_name[i], errs_before);
    endtask

    // single access on m0, sampled just before the closing edge
    task automatic bus_access(addr_t a, data_t d, logic we, output data_t rd);
        @(negedge clk);
        m_addr[0]  = a;
        m_wdata[0] = d;
        m_we[0]    = we;
        m_req[0]   = 1'b1;
        #(ClkPeriod/2 - 5);
        rd = m_rdata[0];
        @(negedge clk);
        idle_masters();
    endtask

    task automatic run_timer_test();
        data_t rd;
        int    cycles;
        int    errs_before;
        errs_before = err_count;
        bus_access(32'h2000_0008, TimerCmp, 1'b1, rd);
        bus_access(32'h2000_0000, 32'h1, 1'b1, rd);  // enable
        cycles = 0;
        while (!int_flag && cycles < TimerBound) begin
            @(negedge clk);
            cycles++;
        end
        check_value("timer int_o rise", 32'd1, {31'b0, int_flag});
        bus_access(32'h2000_0000, 32'h3, 1'b1, rd);  // stay enabled, clear pending
        bus_access(32'h2000_0004, '0, 1'b0, rd);
        check_value("timer int_o clear", '0, {31'b0, int_flag});
        check_value("timer count bound", 32'd1, {31'b0, rd <= TimerCmp});
        report_test("timer", errs_before);
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        gpio_in    = '0;
        gpio_model = '0;
        for (int k = 0; k < RamDepth; k++) begin
            ram_known[k] = 1'b0;
        end
        idle_masters();
        build_table();
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < n_txn; i++) begin
            @(negedge clk);
            apply_txn(i);
            #(ClkPeriod/2 - 5);  // outputs settled, edge still ahead
            check_txn(i);
        end
        @(negedge clk);
        idle_masters();
        run_timer_test();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // reset, table and timer test, plus a margin
    initial begin
        #((ResetCycles + MaxTxn + TimerBudget + 20) * ClkPeriod);
        $display("ERROR: watchdog timeout, the tests did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
logic/rib_pkg.sv
logic/rib_slave_if.sv
logic/ram_blk.sv
logic/gpio_regs.sv
logic/timer_blk.sv
logic/rib.sv
logic/rib_soc_top.sv
sim/rib_tb.sv

/* Makefile */
TOP := rib_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns -f tb.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
